/* design/account_ram.sv */
// Ledger storage, holds the six balances and the chain hash behind two write ports
`timescale 1ns/1ps
`default_nettype none

module account_ram (
	input wire logic clock,
	input wire logic rst,
	input wire logic bal_wren,
	input wire ledger_pkg::ledger_t bal_in,
	input wire logic hash_wren,
	input wire ledger_pkg::hash_t hash_in,
	output ledger_pkg::ledger_t ledger,
	output ledger_pkg::hash_t chain_hash
);

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			ledger <= '0;
			chain_hash <= '0; // Chain starts from zero
		end
		else
		begin
			if (bal_wren)
				ledger <= bal_in;
			if (hash_wren)
				chain_hash <= hash_in;
		end
	end

	// Memory control never issues both writes in the same step
	a_single_write: assert property (@(posedge clock) disable iff (rst)
		!(bal_wren && hash_wren))
		else $error("balance and hash written in the same cycle");

endmodule

`default_nettype wire

/* design/key_table_lfsr.sv */
// Account key generator, steps an LFSR six times after a table_gen pulse and holds table_done
`timescale 1ns/1ps
`default_nettype none

`include "ledger_defines.svh"

module key_table_lfsr (
	input wire logic clock,
	input wire logic rst,
	input wire logic table_gen,
	output ledger_pkg::key_table_t key_table,
	output logic table_done
);
	import ledger_pkg::*;

	key_t lfsr;
	key_t lfsr_next;
	acct_idx_t count; // Slot that the next state goes into
	logic busy;
	logic shift_en;

	// Fibonacci step, feedback enters at bit 0
	assign lfsr_next = {lfsr[`LEDGER_KEY_W-2:0], ^(lfsr & `LEDGER_LFSR_TAPS)};
	assign shift_en = (table_gen || busy) && !table_done;

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			lfsr <= `LEDGER_LFSR_SEED;
			count <= '0;
			busy <= 1'b0;
			table_done <= 1'b0;
		end
		else if (shift_en)
		begin
			lfsr <= lfsr_next;
			if (count == acct_idx_t'(`LEDGER_ACCOUNTS - 1))
			begin
				busy <= 1'b0;
				table_done <= 1'b1; // Held until reset
			end
			else
			begin
				busy <= 1'b1;
				count <= count + 3'd1;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (shift_en)
			key_table.key[count] <= lfsr_next; // Account 0 first
	end

endmodule

`default_nettype wire

/* design/ledger_defines.svh */
// Ledger widths, account count and LFSR constants, included by the package and the RTL
`ifndef LEDGER_DEFINES_SVH
`define LEDGER_DEFINES_SVH

`define LEDGER_ACCOUNTS 6 // Accounts in the ledger word
`define LEDGER_BAL_W 8 // One balance or amount
`define LEDGER_KEY_W 8 // One account key
`define LEDGER_HASH_W 16 // Running chain hash

// LFSR start state
`define LEDGER_LFSR_SEED 8'h5A

// Taps 8, 6, 5, 4 as a bit mask over the state
`define LEDGER_LFSR_TAPS 8'hB8

`endif

/* design/ledger_pkg.sv */
// Shared ledger types and controller state encodings, imported by every RTL block
`default_nettype none

`include "ledger_defines.svh"

package ledger_pkg;

	typedef logic [`LEDGER_BAL_W-1:0] amount_t;
	typedef logic [`LEDGER_KEY_W-1:0] key_t;
	typedef logic [`LEDGER_HASH_W-1:0] hash_t;
	typedef logic [2:0] acct_idx_t;

	// Account 5 sits in the top byte, account 0 in the bottom byte
	typedef struct packed {
		amount_t [`LEDGER_ACCOUNTS-1:0] bal;
	} ledger_t;

	typedef struct packed {
		key_t [`LEDGER_ACCOUNTS-1:0] key;
	} key_table_t;

	// Steps of one withdrawal
	typedef enum logic [2:0] {
		STEP_IDLE,
		STEP_VERIFY,
		STEP_HASH,
		STEP_STORE_HASH,
		STEP_STORE_MEM
	} step_t;

	typedef enum logic [2:0] {
		S_GEN_TABLE,
		S_INIT_MEM,
		S_WAIT_AMOUNT,
		S_WAIT_KEY,
		S_WAIT_START,
		S_TRANSACT
	} main_state_t;

endpackage

`default_nettype wire

/* design/ledger_top.sv */
// Ledger top level, wires the key generator, RAM, controllers and datapath together
`timescale 1ns/1ps
`default_nettype none

module ledger_top (
	input wire logic clock,
	input wire logic rst,
	input wire ledger_pkg::amount_t sw,
	input wire logic load,
	input wire logic start,
	output ledger_pkg::ledger_t ledger,
	output ledger_pkg::hash_t chain_hash,
	output logic ready,
	output logic done,
	output logic rejected
);
	import ledger_pkg::*;

	logic table_gen;
	logic table_done;
	logic init_mem;
	logic init_done;
	logic load_amount;
	logic load_key;
	logic start_trans;
	logic trans_done;
	logic verify_done;
	logic hash_done;
	logic store_done;
	logic bal_wren;
	logic hash_wren;
	step_t step;
	key_table_t key_table;
	ledger_t new_ledger;
	ledger_t bal_in;
	hash_t new_hash;
	hash_t hash_in;

	key_table_lfsr u_lfsr (.clock(clock), .rst(rst), .table_gen(table_gen),
		.key_table(key_table), .table_done(table_done));

	account_ram u_ram (.clock(clock), .rst(rst), .bal_wren(bal_wren), .bal_in(bal_in),
		.hash_wren(hash_wren), .hash_in(hash_in), .ledger(ledger), .chain_hash(chain_hash));

	main_control u_main_ctrl (.clock(clock), .rst(rst), .load(load), .start(start),
		.table_done(table_done), .init_done(init_done), .trans_done(trans_done),
		.table_gen(table_gen), .init_mem(init_mem), .load_amount(load_amount),
		.load_key(load_key), .start_trans(start_trans), .ready(ready), .done(done));

	transaction_control u_trans_ctrl (.clock(clock), .rst(rst), .start_trans(start_trans),
		.verify_done(verify_done), .hash_done(hash_done), .store_done(store_done),
		.step(step), .trans_done(trans_done));

	// Reject flag doubles as the top level status
	verify_datapath u_datapath (.clock(clock), .rst(rst), .sw(sw),
		.load_amount(load_amount), .load_key(load_key), .step(step), .key_table(key_table),
		.ledger(ledger), .chain_hash(chain_hash), .verify_done(verify_done),
		.hash_done(hash_done), .reject(rejected), .new_ledger(new_ledger),
		.new_hash(new_hash));

	memory_control u_mem_ctrl (.clock(clock), .rst(rst), .init_mem(init_mem),
		.key_table(key_table), .step(step), .reject(rejected), .new_ledger(new_ledger),
		.new_hash(new_hash), .bal_wren(bal_wren), .bal_in(bal_in), .hash_wren(hash_wren),
		.hash_in(hash_in), .init_done(init_done), .store_done(store_done));

endmodule

`default_nettype wire

/* design/main_control.sv */
// Top sequencer, builds the key table and memory once, then gates operand loads and starts
`timescale 1ns/1ps
`default_nettype none

module main_control (
	input wire logic clock,
	input wire logic rst,
	input wire logic load,
	input wire logic start,
	input wire logic table_done,
	input wire logic init_done,
	input wire logic trans_done,
	output logic table_gen,
	output logic init_mem,
	output logic load_amount,
	output logic load_key,
	output logic start_trans,
	output logic ready,
	output logic done
);
	import ledger_pkg::*;

	main_state_t state;
	logic req_sent; // Request for the current setup phase already issued

	assign table_gen = (state == S_GEN_TABLE) && !req_sent;
	assign init_mem = (state == S_INIT_MEM) && !req_sent;

	// The load strobe means amount or key depending on the wait state
	assign load_amount = (state == S_WAIT_AMOUNT) && load;
	assign load_key = (state == S_WAIT_KEY) && load;
	assign start_trans = (state == S_WAIT_START) && start;

	assign ready = (state == S_WAIT_AMOUNT) || (state == S_WAIT_KEY)
		|| (state == S_WAIT_START);

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			state <= S_GEN_TABLE;
			req_sent <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				S_GEN_TABLE:
				begin
					req_sent <= !table_done;
					if (table_done)
						state <= S_INIT_MEM;
				end
				S_INIT_MEM:
				begin
					req_sent <= !init_done;
					if (init_done)
						state <= S_WAIT_AMOUNT;
				end
				S_WAIT_AMOUNT:
					if (load)
						state <= S_WAIT_KEY;
				S_WAIT_KEY:
					if (load)
						state <= S_WAIT_START;
				S_WAIT_START:
					if (start)
						state <= S_TRANSACT; // Early starts were dropped before here
				S_TRANSACT:
					if (trans_done)
					begin
						state <= S_WAIT_AMOUNT;
						done <= 1'b1;
					end
				default:
					state <= S_GEN_TABLE;
			endcase
		end
	end

	// Transaction control only finishes a transaction that this sequencer started
	a_done_in_transact: assert property (@(posedge clock) disable iff (rst)
		trans_done |-> state == S_TRANSACT)
		else $error("trans_done outside S_TRANSACT");

endmodule

`default_nettype wire

/* design/memory_control.sv */
// Ledger write control, loads the starting balances and stores accepted hash and balance results
`timescale 1ns/1ps
`default_nettype none

`include "ledger_defines.svh"

module memory_control (
	input wire logic clock,
	input wire logic rst,
	input wire logic init_mem,
	input wire ledger_pkg::key_table_t key_table,
	input wire ledger_pkg::step_t step,
	input wire logic reject,
	input wire ledger_pkg::ledger_t new_ledger,
	input wire ledger_pkg::hash_t new_hash,
	output logic bal_wren,
	output ledger_pkg::ledger_t bal_in,
	output logic hash_wren,
	output ledger_pkg::hash_t hash_in,
	output logic init_done,
	output logic store_done
);
	import ledger_pkg::*;

	ledger_t start_ledger;

	// Each account opens with its own key as balance
	always_comb
	begin
		for (int i = 0; i < `LEDGER_ACCOUNTS; i++)
			start_ledger.bal[i] = amount_t'(key_table.key[i]);
	end

	// Rejected transactions still step through the stores but write nothing
	assign hash_wren = (step == STEP_STORE_HASH) && !reject;
	assign hash_in = new_hash;

	assign bal_wren = init_mem || ((step == STEP_STORE_MEM) && !reject);
	assign bal_in = init_mem ? start_ledger : new_ledger;

	assign store_done = (step == STEP_STORE_HASH) || (step == STEP_STORE_MEM);

	always_ff @(posedge clock)
	begin
		if (rst)
			init_done <= 1'b0;
		else
			init_done <= init_mem; // One cycle after the init write
	end

endmodule

`default_nettype wire

/* design/transaction_control.sv */
// Withdrawal step sequencer, advances verify, hash and the two stores on their done signals
`timescale 1ns/1ps
`default_nettype none

module transaction_control (
	input wire logic clock,
	input wire logic rst,
	input wire logic start_trans,
	input wire logic verify_done,
	input wire logic hash_done,
	input wire logic store_done,
	output ledger_pkg::step_t step,
	output logic trans_done
);
	import ledger_pkg::*;

	logic done_step;

	// Done of whichever block owns the current step
	always_comb
	begin
		case (step)
			STEP_VERIFY: done_step = verify_done;
			STEP_HASH: done_step = hash_done;
			STEP_STORE_HASH, STEP_STORE_MEM: done_step = store_done;
			default: done_step = 1'b0;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			step <= STEP_IDLE;
			trans_done <= 1'b0;
		end
		else
		begin
			trans_done <= 1'b0;
			case (step)
				STEP_IDLE:
					if (start_trans)
						step <= STEP_VERIFY;
				STEP_VERIFY:
					if (done_step)
						step <= STEP_HASH;
				STEP_HASH:
					if (done_step)
						step <= STEP_STORE_HASH;
				STEP_STORE_HASH:
					if (done_step)
						step <= STEP_STORE_MEM;
				STEP_STORE_MEM:
					if (done_step)
					begin
						step <= STEP_IDLE;
						trans_done <= 1'b1;
					end
				default:
					step <= STEP_IDLE;
			endcase
		end
	end

	// Main control must not fire a start while a transaction is still stepping
	a_start_idle: assert property (@(posedge clock) disable iff (rst)
		start_trans |-> step == STEP_IDLE)
		else $error("start_trans outside STEP_IDLE");

endmodule

`default_nettype wire

/* design/verify_datapath.sv */
// Withdrawal datapath, holds the operands, checks key and funds, builds the new ledger and hash
`timescale 1ns/1ps
`default_nettype none

`include "ledger_defines.svh"

module verify_datapath (
	input wire logic clock,
	input wire logic rst,
	input wire ledger_pkg::amount_t sw,
	input wire logic load_amount,
	input wire logic load_key,
	input wire ledger_pkg::step_t step,
	input wire ledger_pkg::key_table_t key_table,
	input wire ledger_pkg::ledger_t ledger,
	input wire ledger_pkg::hash_t chain_hash,
	output logic verify_done,
	output logic hash_done,
	output logic reject,
	output ledger_pkg::ledger_t new_ledger,
	output ledger_pkg::hash_t new_hash
);
	import ledger_pkg::*;

	amount_t amount_reg;
	key_t key_reg;
	acct_idx_t match_idx;
	acct_idx_t idx_reg; // Account found in the verify step
	logic match;
	logic funds_ok;
	ledger_t debit_ledger;
	hash_t rot_hash;

	always_ff @(posedge clock)
	begin
		if (load_amount)
			amount_reg <= sw;
		if (load_key)
			key_reg <= key_t'(sw);
	end

	// Walk down so the lowest matching account wins
	always_comb
	begin
		match = 1'b0;
		match_idx = '0;
		for (int i = `LEDGER_ACCOUNTS - 1; i >= 0; i--)
		begin
			if (key_table.key[i] == key_reg)
			begin
				match = 1'b1;
				match_idx = acct_idx_t'(i);
			end
		end
	end

	assign funds_ok = ledger.bal[match_idx] >= amount_reg;

	always_comb
	begin
		debit_ledger = ledger;
		debit_ledger.bal[idx_reg] = ledger.bal[idx_reg] - amount_reg;
	end

	assign rot_hash = {chain_hash[`LEDGER_HASH_W-2:0], chain_hash[`LEDGER_HASH_W-1]};

	// Each step finishes in the cycle it is entered
	assign verify_done = (step == STEP_VERIFY);
	assign hash_done = (step == STEP_HASH);

	always_ff @(posedge clock)
	begin
		if (rst)
			reject <= 1'b0;
		else if (step == STEP_VERIFY)
			reject <= !match || !funds_ok; // Held until the next verify
	end

	always_ff @(posedge clock)
	begin
		if (step == STEP_VERIFY)
			idx_reg <= match_idx;
		if (step == STEP_HASH)
		begin
			new_ledger <= debit_ledger;
			new_hash <= rot_hash ^ {key_reg, amount_reg}; // Key high, amount low
		end
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Builds the ledger testbench with Verilator, runs it and checks the log for the pass message

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module ledger_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vledger_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "All tests passed" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* sim/ledger_tb.sv */
// Table-driven testbench for the ledger top level, runs withdrawals against a reference model
`timescale 1ns/1ps
`default_nettype none

`include "ledger_defines.svh"

module ledger_tb;
	import ledger_pkg::*;

	localparam int DIRECTED_ROWS = 7;
	localparam int RANDOM_ROWS = 12;
	localparam int NUM_ROWS = DIRECTED_ROWS + RANDOM_ROWS;
	localparam int MAX_CYCLES = 40 * NUM_ROWS + 200;
	localparam int ABSENT = `LEDGER_ACCOUNTS; // Key source code for a key outside the table

	logic clock;
	logic rst;
	amount_t sw;
	logic load;
	logic start;
	ledger_t ledger;
	hash_t chain_hash;
	logic ready;
	logic done;
	logic rejected;

	// Reference model state
	key_t model_keys [`LEDGER_ACCOUNTS];
	amount_t model_bal [`LEDGER_ACCOUNTS];
	hash_t model_hash;
	ledger_t start_ledger;
	key_t absent_key;

	// Stimulus and expected results, one entry per row
	amount_t row_amount [NUM_ROWS];
	int row_key_src [NUM_ROWS];
	logic row_reject [NUM_ROWS];
	ledger_t row_ledger [NUM_ROWS];
	hash_t row_hash [NUM_ROWS];

	int cycle_count;

	ledger_top u_dut (.clock(clock), .rst(rst), .sw(sw), .load(load), .start(start),
		.ledger(ledger), .chain_hash(chain_hash), .ready(ready), .done(done),
		.rejected(rejected));

	initial clock = 1'b0;
	always #2 clock = ~clock;

	always @(posedge clock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= MAX_CYCLES)
		begin
			$display("Run did not finish within %0d cycles", MAX_CYCLES);
			$display("Some tests failed");
			$fatal(1, "Timeout waiting for the DUT");
		end
	end

	task automatic check_value(input string what, input logic [63:0] got,
		input logic [63:0] expected);
		if (got !== expected)
		begin
			$display("ERROR at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
			$display("Some tests failed");
			$fatal(1, "Mismatch on %s", what);
		end
	endtask

	// Fibonacci step shifting left, taps 8, 6, 5 and 4 counted from one
	function automatic key_t lfsr_step(input key_t s);
		return {s[`LEDGER_KEY_W-2:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	function automatic logic key_in_table(input key_t k);
		logic found;
		found = 1'b0;
		for (int i = 0; i < `LEDGER_ACCOUNTS; i++)
			if (model_keys[i] == k)
				found = 1'b1;
		return found;
	endfunction

	function automatic key_t row_key(input int src);
		return (src == ABSENT) ? absent_key : model_keys[src];
	endfunction

	function automatic ledger_t pack_ledger();
		ledger_t l;
		for (int i = 0; i < `LEDGER_ACCOUNTS; i++)
			l.bal[i] = model_bal[i];
		return l;
	endfunction

	task automatic init_model();
		key_t s;
		s = `LEDGER_LFSR_SEED;
		for (int i = 0; i < `LEDGER_ACCOUNTS; i++)
		begin
			s = lfsr_step(s);
			model_keys[i] = s;
			model_bal[i] = amount_t'(s); // Opening balance equals the key
		end
		model_hash = '0;
		start_ledger = pack_ledger();
		absent_key = '0;
		while (key_in_table(absent_key))
			absent_key++;
	endtask

	task automatic apply_model(input amount_t amt, input key_t k, output logic rej);
		int idx;
		idx = -1;
		for (int i = 0; i < `LEDGER_ACCOUNTS; i++)
			if (idx < 0 && model_keys[i] == k)
				idx = i; // First hit is the lowest account
		if (idx < 0 || model_bal[idx] < amt)
			rej = 1'b1;
		else
		begin
			rej = 1'b0;
			model_bal[idx] = model_bal[idx] - amt;
			model_hash = {model_hash[`LEDGER_HASH_W-2:0], model_hash[`LEDGER_HASH_W-1]}
				^ {k, amt};
		end
	endtask

	task automatic add_row(input int r, input amount_t amt, input int src);
		logic rej;
		row_amount[r] = amt;
		row_key_src[r] = src;
		apply_model(amt, row_key(src), rej);
		row_reject[r] = rej;
		row_ledger[r] = pack_ledger();
		row_hash[r] = model_hash;
	endtask

	task automatic add_directed(input int r, input amount_t amt, input int src,
		input logic exp_rej);
		add_row(r, amt, src);
		check_value($sformatf("row %0d model reject", r), row_reject[r], exp_rej);
	endtask

	task automatic build_table();
		amount_t amt;
		int src;
		add_directed(0, 8'h10, 0, 1'b0);
		add_directed(1, 8'hFF, 4, 1'b1); // More than the balance
		add_directed(2, 8'h05, ABSENT, 1'b1);
		add_directed(3, model_keys[4], 4, 1'b0); // Exact balance, account drops to zero
		add_directed(4, 8'h01, 4, 1'b1);
		add_directed(5, 8'h00, 2, 1'b0); // Zero amount still advances the hash
		add_directed(6, 8'h20, 5, 1'b0);
		for (int r = DIRECTED_ROWS; r < NUM_ROWS; r++)
		begin
			amt = amount_t'($urandom % 64);
			src = int'($urandom % (`LEDGER_ACCOUNTS + 1));
			add_row(r, amt, src);
		end
	endtask

	task automatic pulse_load(input amount_t value);
		sw = value;
		load = 1'b1;
		@(negedge clock);
		load = 1'b0;
	endtask

	task automatic pulse_start();
		start = 1'b1;
		@(negedge clock);
		start = 1'b0;
	endtask

	task automatic run_row(input int r);
		key_t k;
		k = row_key(row_key_src[r]);
		pulse_start(); // No operands yet
		check_value($sformatf("row %0d ready after early start", r), ready, 1'b1);
		pulse_load(row_amount[r]);
		pulse_start();
		check_value($sformatf("row %0d ready after start without key", r), ready, 1'b1);
		pulse_load(k);
		pulse_start();
		check_value($sformatf("row %0d ready during transaction", r), ready, 1'b0);
		// Loads while stepping must be dropped
		pulse_load(~row_amount[r]);
		pulse_load(~k);
		while (done !== 1'b1)
			@(negedge clock);
		check_value($sformatf("row %0d ledger", r), ledger, row_ledger[r]);
		check_value($sformatf("row %0d chain_hash", r), chain_hash, row_hash[r]);
		check_value($sformatf("row %0d rejected", r), rejected, row_reject[r]);
	endtask

	initial
	begin
		rst = 1'b1;
		sw = '0;
		load = 1'b0;
		start = 1'b0;
		cycle_count = 0;
		void'($urandom(61));
		init_model();
		build_table();
		repeat (16) @(negedge clock);
		check_value("ready in reset", ready, 1'b0);
		check_value("done in reset", done, 1'b0);
		check_value("rejected in reset", rejected, 1'b0);
		rst = 1'b0;
		while (ready !== 1'b1)
			@(negedge clock);
		check_value("starting ledger", ledger, start_ledger);
		check_value("starting chain_hash", chain_hash, '0);
		check_value("rejected after init", rejected, 1'b0);
		for (int r = 0; r < NUM_ROWS; r++)
			run_row(r);
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+design
design/ledger_pkg.sv
design/key_table_lfsr.sv
design/account_ram.sv
design/main_control.sv
design/transaction_control.sv
design/verify_datapath.sv
design/memory_control.sv
design/ledger_top.sv
sim/ledger_tb.sv
